/* hw/safe_pkg.sv */
/*
 * Shared definitions for the redundant hart wrapper: bus widths,
 * OBI request and response structs, hart mask and redundancy mode
 */

package safe_pkg;

  // Three harts, fixed by the voting scheme
  localparam int unsigned NHARTS = 3;
  localparam int unsigned HART_IDX_W = $clog2(NHARTS);

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH = 4;

  // Returned to an isolated fetch so the hart stays parked
  localparam logic [DATA_WIDTH-1:0] WFI_INSTR = 32'h10500073;

  // One bit per hart
  typedef logic [NHARTS-1:0] hart_mask_t;

  // Hart number for muxing
  typedef logic [HART_IDX_W-1:0] hart_idx_t;

  // Request from a hart towards memory
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [BE_WIDTH-1:0]   be;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] wdata;
  } obi_req_t;

  // Response from memory towards a hart
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [DATA_WIDTH-1:0] rdata;
  } obi_rsp_t;

  // Redundancy modes
  typedef enum logic [1:0] {
    MODE_INDEP = 2'd0,
    MODE_TMR   = 2'd1,
    MODE_DMR   = 2'd2
  } safe_mode_e;

endpackage

/* hw/tmr_voter.sv */
/*
 * Bitwise majority voter over the instruction and data requests
 * of the three harts, with per-hart dissent flags
 */

module tmr_voter (
  input  logic                                       enable_i,
  input  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] instr_req_i,
  input  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] data_req_i,
  output safe_pkg::obi_req_t                        voted_instr_req_o,
  output safe_pkg::obi_req_t                        voted_data_req_o,
  output logic                                       error_o,
  output safe_pkg::hart_mask_t                       error_id_o
);

  safe_pkg::obi_req_t   maj_instr;
  safe_pkg::obi_req_t   maj_data;
  safe_pkg::hart_mask_t dissent;

  // Two out of three per bit
  function automatic safe_pkg::obi_req_t majority(input safe_pkg::obi_req_t a,
                                                  input safe_pkg::obi_req_t b,
                                                  input safe_pkg::obi_req_t c);
    return (a & b) | (a & c) | (b & c);
  endfunction

  assign maj_instr = majority(instr_req_i[0], instr_req_i[1], instr_req_i[2]);
  assign maj_data  = majority(data_req_i[0], data_req_i[1], data_req_i[2]);

  // A hart dissents if either of its buses differs from the vote
  for (genvar i = 0; i < safe_pkg::NHARTS; i++) begin : g_dissent
    assign dissent[i] = (instr_req_i[i] != maj_instr) || (data_req_i[i] != maj_data);
  end

  always_comb begin
    if (enable_i) begin
      voted_instr_req_o = maj_instr;
      voted_data_req_o  = maj_data;
      error_id_o        = dissent;
      error_o           = |dissent;
    end else begin
      voted_instr_req_o = '0;
      voted_data_req_o  = '0;
      error_id_o        = '0;
      error_o           = 1'b0;
    end
  end

endmodule

/* hw/dmr_comparator.sv */
/*
 * Lockstep check of the master hart against its partner on both buses
 */

module dmr_comparator (
  input  logic               enable_i,
  input  safe_pkg::obi_req_t master_instr_req_i,
  input  safe_pkg::obi_req_t partner_instr_req_i,
  input  safe_pkg::obi_req_t master_data_req_i,
  input  safe_pkg::obi_req_t partner_data_req_i,
  output logic               error_o
);

  logic instr_mismatch;
  logic data_mismatch;

  // Any field counts, including idle payload
  assign instr_mismatch = (master_instr_req_i != partner_instr_req_i);
  assign data_mismatch  = (master_data_req_i != partner_data_req_i);

  assign error_o = enable_i && (instr_mismatch || data_mismatch);

endmodule

/* hw/wfi_isolator.sv */
/*
 * Local OBI responder for a hart parked in wait-for-interrupt.
 * Grants every request and answers one cycle later, and flushes
 * an rvalid still owed from before the hold
 */

module wfi_isolator (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  logic               hold_i,
  input  safe_pkg::obi_req_t instr_req_i,
  input  safe_pkg::obi_req_t data_req_i,
  input  safe_pkg::obi_rsp_t instr_rsp_i,
  input  safe_pkg::obi_rsp_t data_rsp_i,
  output safe_pkg::obi_rsp_t iso_instr_rsp_o,
  output safe_pkg::obi_rsp_t iso_data_rsp_o
);

  // Index 0 is the instruction bus, index 1 the data bus
  safe_pkg::obi_req_t [1:0]                          bus_req;
  safe_pkg::obi_rsp_t [1:0]                          bus_rsp;
  safe_pkg::obi_rsp_t [1:0]                          iso_rsp;
  logic [1:0][safe_pkg::DATA_WIDTH-1:0]              iso_rdata;
  logic [1:0]                                        valid_q;
  logic [1:0]                                        pending_q;

  assign bus_req   = {data_req_i, instr_req_i};
  assign bus_rsp   = {data_rsp_i, instr_rsp_i};
  assign iso_rdata = {{safe_pkg::DATA_WIDTH{1'b0}}, safe_pkg::WFI_INSTR};

  for (genvar b = 0; b < 2; b++) begin : g_bus
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        valid_q[b]   <= 1'b0;
        pending_q[b] <= 1'b0;
      end else if (hold_i) begin
        // Grant is req, so every request is answered next cycle
        valid_q[b]   <= bus_req[b].req;
        pending_q[b] <= 1'b0;
      end else begin
        valid_q[b]   <= 1'b0;
        // Outstanding until memory returns its rvalid
        pending_q[b] <= (bus_req[b].req & bus_rsp[b].gnt) |
                        (pending_q[b] & ~bus_rsp[b].rvalid);
      end
    end

    assign iso_rsp[b].gnt    = bus_req[b].req;
    assign iso_rsp[b].rvalid = valid_q[b] | pending_q[b];
    assign iso_rsp[b].rdata  = iso_rdata[b];
  end

  assign iso_instr_rsp_o = iso_rsp[0];
  assign iso_data_rsp_o  = iso_rsp[1];

endmodule

/* hw/redundancy_router.sv */
/*
 * Request steering and response fan-out between the harts and the
 * memory ports, master hart latch and registered sleep mask
 */

module redundancy_router (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  safe_pkg::safe_mode_e                       mode_i,
  input  safe_pkg::hart_mask_t                       master_i,
  input  safe_pkg::hart_mask_t                       dmr_pair_i,
  input  safe_pkg::hart_mask_t                       wfi_hold_i,
  input  safe_pkg::hart_mask_t                       sleep_i,
  input  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] core_instr_req_i,
  input  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] core_data_req_i,
  input  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] mem_instr_rsp_i,
  input  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] mem_data_rsp_i,
  input  safe_pkg::obi_req_t                        voted_instr_req_i,
  input  safe_pkg::obi_req_t                        voted_data_req_i,
  input  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] iso_instr_rsp_i,
  input  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] iso_data_rsp_i,
  output safe_pkg::hart_mask_t                       sleep_o,
  output safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] mem_instr_req_o,
  output safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] mem_data_req_o,
  output safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] core_instr_rsp_o,
  output safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] core_data_rsp_o,
  output logic                                       vote_en_o,
  output logic                                       cmp_en_o,
  output safe_pkg::obi_req_t                        partner_instr_req_o,
  output safe_pkg::obi_req_t                        partner_data_req_o,
  output safe_pkg::obi_req_t                        master_instr_req_o,
  output safe_pkg::obi_req_t                        master_data_req_o
);

  safe_pkg::hart_mask_t master_q;
  safe_pkg::hart_mask_t sleep_q;
  safe_pkg::hart_idx_t  master_idx;
  safe_pkg::hart_idx_t  partner_idx;
  logic                 tmr_mode;
  logic                 dmr_mode;

  // Master may only move while every hart is asleep
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      master_q <= safe_pkg::hart_mask_t'(1);
    end else if (&sleep_i) begin
      master_q <= master_i;
    end
  end

  // Registered sleep for output isolation
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      sleep_q <= '0;
    end else begin
      sleep_q <= sleep_i;
    end
  end

  assign sleep_o = sleep_q;

  // Master and partner numbers, lowest set bit wins
  always_comb begin
    master_idx  = '0;
    partner_idx = '0;
    for (int i = safe_pkg::NHARTS - 1; i >= 0; i--) begin
      if (master_q[i]) begin
        master_idx = safe_pkg::hart_idx_t'(i);
      end
      if (dmr_pair_i[i] && !master_q[i]) begin
        partner_idx = safe_pkg::hart_idx_t'(i);
      end
    end
  end

  assign tmr_mode  = (mode_i == safe_pkg::MODE_TMR);
  assign dmr_mode  = (mode_i == safe_pkg::MODE_DMR);
  assign vote_en_o = tmr_mode;
  assign cmp_en_o  = dmr_mode;

  assign master_instr_req_o  = core_instr_req_i[master_idx];
  assign master_data_req_o   = core_data_req_i[master_idx];
  assign partner_instr_req_o = core_instr_req_i[partner_idx];
  assign partner_data_req_o  = core_data_req_i[partner_idx];

  for (genvar i = 0; i < safe_pkg::NHARTS; i++) begin : g_port
    // Only the master port is live in the redundant modes
    always_comb begin
      if (tmr_mode) begin
        mem_instr_req_o[i] = master_q[i] ? voted_instr_req_i : '0;
        mem_data_req_o[i]  = master_q[i] ? voted_data_req_i : '0;
      end else if (dmr_mode) begin
        mem_instr_req_o[i] = master_q[i] ? core_instr_req_i[i] : '0;
        mem_data_req_o[i]  = master_q[i] ? core_data_req_i[i] : '0;
      end else begin
        mem_instr_req_o[i] = core_instr_req_i[i];
        mem_data_req_o[i]  = core_data_req_i[i];
      end
    end

    // Held harts are answered locally
    always_comb begin
      if (wfi_hold_i[i]) begin
        core_instr_rsp_o[i] = iso_instr_rsp_i[i];
        core_data_rsp_o[i]  = iso_data_rsp_i[i];
      end else if (tmr_mode || (dmr_mode && dmr_pair_i[i])) begin
        core_instr_rsp_o[i] = mem_instr_rsp_i[master_idx];
        core_data_rsp_o[i]  = mem_data_rsp_i[master_idx];
      end else begin
        core_instr_rsp_o[i] = mem_instr_rsp_i[i];
        core_data_rsp_o[i]  = mem_data_rsp_i[i];
      end
    end
  end

endmodule

/* hw/safe_cpu_wrapper.sv */
/*
 * Redundancy wrapper top: router, majority voter, lockstep
 * comparator and one WFI isolator per hart
 */

module safe_cpu_wrapper (
  input  logic                                       clk_i,
  input  logic                                       rst_ni,
  input  safe_pkg::safe_mode_e                       mode_i,
  input  safe_pkg::hart_mask_t                       master_i,
  input  safe_pkg::hart_mask_t                       dmr_pair_i,
  input  safe_pkg::hart_mask_t                       wfi_hold_i,
  input  safe_pkg::hart_mask_t                       sleep_i,
  input  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] core_instr_req_i,
  input  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] core_data_req_i,
  input  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] mem_instr_rsp_i,
  input  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] mem_data_rsp_i,
  output safe_pkg::hart_mask_t                       sleep_o,
  output safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] core_instr_rsp_o,
  output safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] core_data_rsp_o,
  output safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] mem_instr_req_o,
  output safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] mem_data_req_o,
  output logic                                       tmr_error_o,
  output logic                                       dmr_error_o,
  output safe_pkg::hart_mask_t                       tmr_error_id_o
);

  safe_pkg::obi_req_t                        voted_instr_req;
  safe_pkg::obi_req_t                        voted_data_req;
  safe_pkg::obi_req_t                        master_instr_req;
  safe_pkg::obi_req_t                        master_data_req;
  safe_pkg::obi_req_t                        partner_instr_req;
  safe_pkg::obi_req_t                        partner_data_req;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] iso_instr_rsp;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] iso_data_rsp;
  logic                                      vote_en;
  logic                                      cmp_en;

  redundancy_router u_router (
    .clk_i,
    .rst_ni,
    .mode_i,
    .master_i,
    .dmr_pair_i,
    .wfi_hold_i,
    .sleep_i,
    .core_instr_req_i,
    .core_data_req_i,
    .mem_instr_rsp_i,
    .mem_data_rsp_i,
    .voted_instr_req_i  (voted_instr_req),
    .voted_data_req_i   (voted_data_req),
    .iso_instr_rsp_i    (iso_instr_rsp),
    .iso_data_rsp_i     (iso_data_rsp),
    .sleep_o,
    .mem_instr_req_o,
    .mem_data_req_o,
    .core_instr_rsp_o,
    .core_data_rsp_o,
    .vote_en_o          (vote_en),
    .cmp_en_o           (cmp_en),
    .partner_instr_req_o(partner_instr_req),
    .partner_data_req_o (partner_data_req),
    .master_instr_req_o (master_instr_req),
    .master_data_req_o  (master_data_req)
  );

  tmr_voter u_voter (
    .enable_i         (vote_en),
    .instr_req_i      (core_instr_req_i),
    .data_req_i       (core_data_req_i),
    .voted_instr_req_o(voted_instr_req),
    .voted_data_req_o (voted_data_req),
    .error_o          (tmr_error_o),
    .error_id_o       (tmr_error_id_o)
  );

  dmr_comparator u_comparator (
    .enable_i           (cmp_en),
    .master_instr_req_i (master_instr_req),
    .partner_instr_req_i(partner_instr_req),
    .master_data_req_i  (master_data_req),
    .partner_data_req_i (partner_data_req),
    .error_o            (dmr_error_o)
  );

  // Isolators watch the response their hart actually sees
  for (genvar i = 0; i < safe_pkg::NHARTS; i++) begin : g_iso
    wfi_isolator u_isolator (
      .clk_i,
      .rst_ni,
      .hold_i         (wfi_hold_i[i]),
      .instr_req_i    (core_instr_req_i[i]),
      .data_req_i     (core_data_req_i[i]),
      .instr_rsp_i    (core_instr_rsp_o[i]),
      .data_rsp_i     (core_data_rsp_o[i]),
      .iso_instr_rsp_o(iso_instr_rsp[i]),
      .iso_data_rsp_o (iso_data_rsp[i])
    );
  end

endmodule

/* dv/tb_clock_gen.sv */
/*
 * Testbench clock (4 ns period) and active-low reset held for 8 cycles
 */

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o;
    end
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    #1 rst_no = 1'b1;
  end

endmodule

/* dv/safe_cpu_wrapper_tb.sv */
/*
 * Testbench for the redundancy wrapper: random stimulus over all modes,
 * expected values from the routing rules, assertions and final report
 */

module safe_cpu_wrapper_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                                      clk;
  logic                                      rst_n;
  safe_pkg::safe_mode_e                      mode;
  safe_pkg::hart_mask_t                      master;
  safe_pkg::hart_mask_t                      dmr_pair;
  safe_pkg::hart_mask_t                      wfi_hold;
  safe_pkg::hart_mask_t                      sleep;
  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] core_instr_req;
  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] core_data_req;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] mem_instr_rsp;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] mem_data_rsp;
  safe_pkg::hart_mask_t                      sleep_out;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] core_instr_rsp;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] core_data_rsp;
  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] mem_instr_req;
  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] mem_data_req;
  logic                                      tmr_error;
  logic                                      dmr_error;
  safe_pkg::hart_mask_t                      tmr_error_id;

  // Reference state and expected outputs
  safe_pkg::hart_mask_t                      exp_master;
  safe_pkg::hart_mask_t                      sleep_d;
  safe_pkg::hart_mask_t                      prev_hold_q;
  logic [safe_pkg::NHARTS-1:0][1:0]          prev_req_q;
  logic [safe_pkg::NHARTS-1:0][1:0]          owed_q;
  safe_pkg::obi_req_t                        maj_instr;
  safe_pkg::obi_req_t                        maj_data;
  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] exp_mem_instr;
  safe_pkg::obi_req_t [safe_pkg::NHARTS-1:0] exp_mem_data;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] exp_core_instr;
  safe_pkg::obi_rsp_t [safe_pkg::NHARTS-1:0] exp_core_data;
  safe_pkg::hart_mask_t                      exp_tmr_id;
  logic                                      exp_tmr_err;
  logic                                      exp_dmr_err;

  logic [31:0] rng;
  int          cycles;
  int          value_errors;
  int          other_errors;

  tb_clock_gen u_clock_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  safe_cpu_wrapper dut_i (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .mode_i          (mode),
    .master_i        (master),
    .dmr_pair_i      (dmr_pair),
    .wfi_hold_i      (wfi_hold),
    .sleep_i         (sleep),
    .core_instr_req_i(core_instr_req),
    .core_data_req_i (core_data_req),
    .mem_instr_rsp_i (mem_instr_rsp),
    .mem_data_rsp_i  (mem_data_rsp),
    .sleep_o         (sleep_out),
    .core_instr_rsp_o(core_instr_rsp),
    .core_data_rsp_o (core_data_rsp),
    .mem_instr_req_o (mem_instr_req),
    .mem_data_req_o  (mem_data_req),
    .tmr_error_o     (tmr_error),
    .dmr_error_o     (dmr_error),
    .tmr_error_id_o  (tmr_error_id)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int lowest_hart(input safe_pkg::hart_mask_t mask);
    int idx;
    idx = 0;
    for (int i = safe_pkg::NHARTS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = i;
      end
    end
    return idx;
  endfunction

  task automatic value_error(input string name,
                             input logic [$bits(safe_pkg::obi_req_t)-1:0] got,
                             input logic [$bits(safe_pkg::obi_req_t)-1:0] exp);
    value_errors++;
    $display("ERR %s got %h exp %h (cycle %0d)", name, got, exp, cycles);
  endtask

  task automatic rand_word(output logic [31:0] w);
    rng = xorshift(rng);
    w = rng;
  endtask

  task automatic rand_req(output safe_pkg::obi_req_t r);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    rand_word(w0);
    rand_word(w1);
    rand_word(w2);
    r = {w0[5:0], w1, w2};
  endtask

  task automatic rand_mem_rsp();
    logic [31:0] w;
    for (int h = 0; h < safe_pkg::NHARTS; h++) begin
      rand_word(w);
      mem_instr_rsp[h] = {w[1:0], xorshift(w)};
      rand_word(w);
      mem_data_rsp[h] = {w[1:0], xorshift(w)};
    end
  endtask

  task automatic drive_own_reqs();
    for (int h = 0; h < safe_pkg::NHARTS; h++) begin
      rand_req(core_instr_req[h]);
      rand_req(core_data_req[h]);
    end
  endtask

  // Same request on every hart, with one hart flipped in a few bits
  task automatic drive_shared_reqs(input int bad_hart);
    safe_pkg::obi_req_t ri;
    safe_pkg::obi_req_t rd;
    safe_pkg::obi_req_t flip;
    rand_req(ri);
    rand_req(rd);
    rand_req(flip);
    for (int h = 0; h < safe_pkg::NHARTS; h++) begin
      core_instr_req[h] = ri;
      core_data_req[h]  = rd;
    end
    if (bad_hart >= 0 && bad_hart < safe_pkg::NHARTS) begin
      // Either bus may carry the fault
      if (flip.req) begin
        core_data_req[bad_hart] = rd ^ (flip | safe_pkg::obi_req_t'(1));
      end else begin
        core_instr_req[bad_hart] = ri ^ (flip | safe_pkg::obi_req_t'(1));
      end
    end
  endtask

  // Sleep mask that never has all harts asleep
  task automatic rand_awake_sleep();
    logic [31:0] w;
    rand_word(w);
    sleep = w[2:0] & ~safe_pkg::hart_mask_t'(1 << (w[4:3] % 3));
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    rand_mem_rsp();
  endtask

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_master  <= 3'b001;
      sleep_d     <= '0;
      prev_hold_q <= '0;
      prev_req_q  <= '0;
      owed_q      <= '0;
    end else begin
      if (&sleep) begin
        exp_master <= master;
      end
      sleep_d     <= sleep;
      prev_hold_q <= wfi_hold;
      for (int h = 0; h < safe_pkg::NHARTS; h++) begin
        prev_req_q[h] <= {core_data_req[h].req, core_instr_req[h].req};
        if (wfi_hold[h]) begin
          owed_q[h] <= '0;
        end else begin
          // Granted before the hold and still waiting for rvalid
          owed_q[h][0] <= (core_instr_req[h].req & exp_core_instr[h].gnt) |
                          (owed_q[h][0] & ~exp_core_instr[h].rvalid);
          owed_q[h][1] <= (core_data_req[h].req & exp_core_data[h].gnt) |
                          (owed_q[h][1] & ~exp_core_data[h].rvalid);
        end
      end
    end
  end

  always_comb begin
    int m;
    int p;
    logic shared;
    m = lowest_hart(exp_master);
    p = lowest_hart(dmr_pair & ~exp_master);
    maj_instr = (core_instr_req[0] & core_instr_req[1]) |
                (core_instr_req[0] & core_instr_req[2]) |
                (core_instr_req[1] & core_instr_req[2]);
    maj_data  = (core_data_req[0] & core_data_req[1]) |
                (core_data_req[0] & core_data_req[2]) |
                (core_data_req[1] & core_data_req[2]);
    for (int h = 0; h < safe_pkg::NHARTS; h++) begin
      exp_tmr_id[h] = (mode == safe_pkg::MODE_TMR) &&
                      ((core_instr_req[h] != maj_instr) || (core_data_req[h] != maj_data));
      case (mode)
        safe_pkg::MODE_TMR: begin
          exp_mem_instr[h] = (h == m) ? maj_instr : '0;
          exp_mem_data[h]  = (h == m) ? maj_data : '0;
        end
        safe_pkg::MODE_DMR: begin
          exp_mem_instr[h] = (h == m) ? core_instr_req[h] : '0;
          exp_mem_data[h]  = (h == m) ? core_data_req[h] : '0;
        end
        default: begin
          exp_mem_instr[h] = core_instr_req[h];
          exp_mem_data[h]  = core_data_req[h];
        end
      endcase
      shared = (mode == safe_pkg::MODE_TMR) || (mode == safe_pkg::MODE_DMR && dmr_pair[h]);
      if (wfi_hold[h]) begin
        exp_core_instr[h].gnt    = core_instr_req[h].req;
        exp_core_instr[h].rvalid = prev_hold_q[h] ? prev_req_q[h][0] : owed_q[h][0];
        exp_core_instr[h].rdata  = safe_pkg::WFI_INSTR;
        exp_core_data[h].gnt     = core_data_req[h].req;
        exp_core_data[h].rvalid  = prev_hold_q[h] ? prev_req_q[h][1] : owed_q[h][1];
        exp_core_data[h].rdata   = '0;
      end else begin
        exp_core_instr[h] = shared ? mem_instr_rsp[m] : mem_instr_rsp[h];
        exp_core_data[h]  = shared ? mem_data_rsp[m] : mem_data_rsp[h];
      end
    end
    exp_tmr_err = |exp_tmr_id;
    exp_dmr_err = (mode == safe_pkg::MODE_DMR) &&
                  ((core_instr_req[m] != core_instr_req[p]) ||
                   (core_data_req[m] != core_data_req[p]));
  end

  for (genvar h = 0; h < safe_pkg::NHARTS; h++) begin : g_check
    a_mem_instr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_instr_req[h] == exp_mem_instr[h])
      else value_error($sformatf("mem_instr_req_o[%0d]", h),
                       $sampled(mem_instr_req[h]), $sampled(exp_mem_instr[h]));
    a_mem_data: assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_req[h] == exp_mem_data[h])
      else value_error($sformatf("mem_data_req_o[%0d]", h),
                       $sampled(mem_data_req[h]), $sampled(exp_mem_data[h]));
    a_core_instr: assert property (@(posedge clk) disable iff (!rst_n)
        core_instr_rsp[h] == exp_core_instr[h])
      else value_error($sformatf("core_instr_rsp_o[%0d]", h),
                       $sampled(core_instr_rsp[h]), $sampled(exp_core_instr[h]));
    a_core_data: assert property (@(posedge clk) disable iff (!rst_n)
        core_data_rsp[h] == exp_core_data[h])
      else value_error($sformatf("core_data_rsp_o[%0d]", h),
                       $sampled(core_data_rsp[h]), $sampled(exp_core_data[h]));
  end

  a_tmr_err: assert property (@(posedge clk) disable iff (!rst_n) tmr_error == exp_tmr_err)
    else value_error("tmr_error_o", $sampled(tmr_error), $sampled(exp_tmr_err));
  a_tmr_id: assert property (@(posedge clk) disable iff (!rst_n) tmr_error_id == exp_tmr_id)
    else value_error("tmr_error_id_o", $sampled(tmr_error_id), $sampled(exp_tmr_id));
  a_dmr_err: assert property (@(posedge clk) disable iff (!rst_n) dmr_error == exp_dmr_err)
    else value_error("dmr_error_o", $sampled(dmr_error), $sampled(exp_dmr_err));
  a_sleep: assert property (@(posedge clk) disable iff (!rst_n) sleep_out == sleep_d)
    else value_error("sleep_o", $sampled(sleep_out), $sampled(sleep_d));

  // About five times the length of the stimulus
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == 2000) begin
      other_errors++;
      $display("Timeout, the run did not complete within 2000 cycles");
      $display("Run ended after %0d cycles with %0d value errors and %0d other errors",
               cycles, value_errors, other_errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    logic [31:0] w;
    rng            = 32'hcb21;
    cycles         = 0;
    value_errors   = 0;
    other_errors   = 0;
    mode           = safe_pkg::MODE_INDEP;
    master         = 3'b001;
    dmr_pair       = 3'b011;
    wfi_hold       = '0;
    sleep          = '0;
    core_instr_req = '0;
    core_data_req  = '0;
    mem_instr_rsp  = '0;
    mem_data_rsp   = '0;
    @(posedge rst_n);

    // Independent ports, with random sleep
    for (int i = 0; i < 60; i++) begin
      next_cycle();
      drive_own_reqs();
      rand_awake_sleep();
    end

    // TMR with one corrupted hart, then agreeing harts
    mode = safe_pkg::MODE_TMR;
    for (int i = 0; i < 60; i++) begin
      next_cycle();
      drive_shared_reqs(i < 40 ? i % 3 : -1);
    end

    // DMR over both pairs that contain hart 0; odd cycles corrupt the partner
    mode = safe_pkg::MODE_DMR;
    for (int i = 0; i < 80; i++) begin
      next_cycle();
      dmr_pair = (i < 40) ? 3'b011 : 3'b101;
      drive_shared_reqs(i[0] ? lowest_hart(dmr_pair & 3'b110) : lowest_hart(~dmr_pair));
    end

    // Holds toggling slowly so grants before a hold are still owed
    for (int i = 0; i < 70; i++) begin
      next_cycle();
      mode = (i < 40) ? safe_pkg::MODE_INDEP : safe_pkg::MODE_TMR;
      rand_word(w);
      if (w[1:0] == 2'd0) begin
        wfi_hold = wfi_hold ^ safe_pkg::hart_mask_t'(1 << (w[3:2] % 3));
      end
      drive_own_reqs();
    end
    next_cycle();
    wfi_hold = '0;

    // Master moves only after a cycle with every hart asleep
    mode   = safe_pkg::MODE_TMR;
    master = 3'b010;
    for (int i = 0; i < 20; i++) begin
      next_cycle();
      drive_shared_reqs(i % 3);
      rand_awake_sleep();
    end
    next_cycle();
    sleep = 3'b111;
    for (int i = 0; i < 40; i++) begin
      next_cycle();
      rand_awake_sleep();
      mode     = (i < 20) ? safe_pkg::MODE_TMR : safe_pkg::MODE_DMR;
      dmr_pair = 3'b110;
      drive_shared_reqs(i % 3);
    end
    master = 3'b100;
    for (int i = 0; i < 10; i++) begin
      next_cycle();
      rand_awake_sleep();
      drive_shared_reqs(-1);
    end
    next_cycle();
    sleep = 3'b111;
    for (int i = 0; i < 20; i++) begin
      next_cycle();
      rand_awake_sleep();
      dmr_pair = 3'b101;
      drive_shared_reqs(i % 3);
    end
    next_cycle();
    next_cycle();

    $display("Run ended after %0d cycles with %0d value errors and %0d other errors",
             cycles, value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* project.f */
hw/safe_pkg.sv
hw/tmr_voter.sv
hw/dmr_comparator.sv
hw/wfi_isolator.sv
hw/redundancy_router.sv
hw/safe_cpu_wrapper.sv
dv/tb_clock_gen.sv
dv/safe_cpu_wrapper_tb.sv
